/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_uart_receiver
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
logic/uart_rx_pkg.sv
logic/rx_line_sync.sv
logic/rx_shift_register.sv
logic/rx_byte_fifo.sv
logic/uart_receiver.sv
verification/tb_clock_gen.sv
verification/uart_receiver_assert.sv
verification/tb_uart_receiver.sv

/* logic/rx_byte_fifo.sv */
`timescale 1ns/10ps

module rx_byte_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   baud16,
    input  logic                   reset,
    input  uart_rx_pkg::rx_frame_t frame,
    input  logic                   frame_valid,
    input  logic                   rd_en,
    output uart_rx_pkg::rx_frame_t rd_frame,
    output logic                   empty,
    output logic                   overrun
);

    import uart_rx_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // one extra bit tells a full buffer from an empty one.
    typedef logic [ADDR_W:0] fifo_ptr_t;

    rx_frame_t mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      full;
    logic      do_write;
    logic      do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign do_write = frame_valid & ~full;
    assign do_read  = rd_en & ~empty;

    // fall-through head.
    assign rd_frame = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge baud16 or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            overrun <= 1'b0;
            for (int i = 0; i < FIFO_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (do_write) begin
                mem[wr_ptr[ADDR_W-1:0]] <= frame;
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
            // frame lost, sticky until reset.
            if (frame_valid && full) begin
                overrun <= 1'b1;
            end
        end
    end

endmodule

/* logic/rx_line_sync.sv */
`timescale 1ns/10ps

module rx_line_sync (
    input  logic baud16,
    input  logic reset,
    input  logic serial_in,
    output logic line_clean
);

    logic [1:0] sync_q;
    logic [2:0] history;

    // the line idles high, so everything starts at 1.
    always_ff @(posedge baud16 or posedge reset) begin
        if (reset) begin
            sync_q  <= 2'b11;
            history <= 3'b111;
        end else begin
            sync_q  <= {sync_q[0], serial_in};
            history <= {history[1:0], sync_q[1]};
        end
    end

    // two out of three.
    // a level held for a single tick never wins the vote.
    assign line_clean = (history[0] & history[1]) |
                        (history[0] & history[2]) |
                        (history[1] & history[2]);

endmodule

/* logic/rx_shift_register.sv */
`timescale 1ns/10ps

module rx_shift_register (
    input  logic                  baud16,
    input  logic                  reset,
    input  logic                  line_clean,
    output uart_rx_pkg::rx_frame_t frame,
    output logic                  frame_valid
);

    import uart_rx_pkg::*;

    rx_state_t     state;
    sample_count_t sample_count;
    bit_index_t    bit_index;
    rx_byte_t      shift_data;
    logic          line_prev;
    logic          line_fall;
    logic          sample_tick;
    logic          last_bit;

    assign line_fall   = line_prev & ~line_clean;
    assign sample_tick = (sample_count == sample_count_t'(BIT_TICKS - 1));
    assign last_bit    = (bit_index == bit_index_t'(DATA_BITS - 1));

    always_ff @(posedge baud16 or posedge reset) begin
        if (reset) begin
            state        <= idle;
            sample_count <= '0;
            bit_index    <= '0;
            line_prev    <= 1'b1;
            frame_valid  <= 1'b0;
        end else begin
            line_prev   <= line_clean;
            frame_valid <= 1'b0;

            case (state)
                idle: begin
                    sample_count <= '0;
                    if (line_fall) begin
                        state <= start;
                    end
                end

                start: begin
                    sample_count <= sample_count + sample_count_t'(1);
                    // middle of the start bit.
                    if (sample_count == MID_SAMPLE) begin
                        sample_count <= '0;
                        bit_index    <= '0;
                        if (line_clean) begin
                            // false start, the line went back up.
                            state <= idle;
                        end else begin
                            state <= data;
                        end
                    end
                end

                data: begin
                    // counter wraps to 0 after the sample tick.
                    sample_count <= sample_count + sample_count_t'(1);
                    if (sample_tick) begin
                        bit_index <= bit_index + bit_index_t'(1);
                        if (last_bit) begin
                            state <= stop;
                        end
                    end
                end

                stop: begin
                    sample_count <= sample_count + sample_count_t'(1);
                    if (sample_tick) begin
                        frame_valid <= 1'b1;
                        state       <= idle;
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // lsb first, so new bits enter at the top and move down.
    always_ff @(posedge baud16) begin
        if (state == data && sample_tick) begin
            shift_data <= {line_clean, shift_data[DATA_BITS-1:1]};
        end
    end

    // a low stop bit still goes out, flagged.
    always_ff @(posedge baud16) begin
        if (state == stop && sample_tick) begin
            frame.data          <= shift_data;
            frame.framing_error <= ~line_clean;
        end
    end

endmodule

/* logic/uart_receiver.sv */
`timescale 1ns/10ps

module uart_receiver #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   baud16,
    input  logic                   reset,
    input  logic                   serial_in,
    input  logic                   rd_en,
    output uart_rx_pkg::rx_frame_t rd_frame,
    output logic                   empty,
    output logic                   overrun
);

    import uart_rx_pkg::*;

    logic      line_clean;
    rx_frame_t frame;
    logic      frame_valid;

    // metastability and noise on the raw line.
    rx_line_sync u_line_sync (
        .baud16     (baud16),
        .reset      (reset),
        .serial_in  (serial_in),
        .line_clean (line_clean)
    );

    // 8N1 framing.
    rx_shift_register u_shift_register (
        .baud16      (baud16),
        .reset       (reset),
        .line_clean  (line_clean),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    // holds frames until the host pops them.
    rx_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_byte_fifo (
        .baud16      (baud16),
        .reset       (reset),
        .frame       (frame),
        .frame_valid (frame_valid),
        .rd_en       (rd_en),
        .rd_frame    (rd_frame),
        .empty       (empty),
        .overrun     (overrun)
    );

endmodule

/* logic/uart_rx_pkg.sv */
package uart_rx_pkg;

    // one received data byte.
    typedef logic [7:0] rx_byte_t;

    // position within one bit time, in baud16 ticks.
    typedef logic [3:0] sample_count_t;

    // index of the data bit being received.
    typedef logic [3:0] bit_index_t;

    // what the receiver hands to the FIFO and the FIFO hands to the host.
    typedef struct packed {
        rx_byte_t data;
        logic     framing_error;
    } rx_frame_t;

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } rx_state_t;

    // tick at which the start bit is checked again.
    localparam sample_count_t MID_SAMPLE = 4'd7;

    // baud16 ticks per bit.
    localparam int BIT_TICKS = 16;

    // data bits per 8N1 frame.
    localparam int DATA_BITS = 8;

endpackage

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic baud16,
    output logic reset
);

    initial begin
        baud16 = 1'b0;
        forever begin
            #(PERIOD / 2.0);
            baud16 = ~baud16;
        end
    end

    // released 1 ns after an edge, like the other inputs.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge baud16);
        #1;
        reset = 1'b0;
    end

endmodule

/* verification/tb_uart_receiver.sv */
`timescale 1ns/10ps

module tb_uart_receiver;

    import uart_rx_pkg::*;

    localparam int FIFO_DEPTH      = 4;
    localparam int RANDOM_FRAMES   = 40;
    localparam int FRAMING_FRAMES  = 16;
    localparam int RATE_FRAMES     = 12;
    localparam int READ_WAIT_TICKS = 400;
    localparam int FRAMES_SENT     = RANDOM_FRAMES + FRAMING_FRAMES + 1 +
                                     (FIFO_DEPTH + 2) + RATE_FRAMES;

    // 10 bits of at most 17 ticks at 8 ns, plus room for gaps and glitches.
    localparam real TIMEOUT_NS = real'(FRAMES_SENT) * 10.0 * 17.0 * 8.0 + 40000.0;

    logic      baud16;
    logic      reset;
    logic      serial_in;
    logic      rd_en;
    rx_frame_t rd_frame;
    logic      empty;
    logic      overrun;

    rx_frame_t expected_q[$];
    logic      expected_overrun;
    int        checks_passed;
    int        checks_failed;

    tb_clock_gen #(
        .PERIOD       (8.0),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .baud16 (baud16),
        .reset  (reset)
    );

    uart_receiver #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .baud16    (baud16),
        .reset     (reset),
        .serial_in (serial_in),
        .rd_en     (rd_en),
        .rd_frame  (rd_frame),
        .empty     (empty),
        .overrun   (overrun)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            checks_failed++;
            $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
        end else begin
            checks_passed++;
        end
    endtask

    // inputs change 1 ns after the rising edge.
    task automatic wait_tick();
        @(posedge baud16);
        #1;
    endtask

    task automatic idle_line(input int ticks);
        serial_in = 1'b1;
        repeat (ticks) wait_tick();
    endtask

    // even and odd bits may get different lengths to stress the sampling point.
    task automatic send_frame(input rx_byte_t data_byte, input logic stop_bit,
                              input int even_ticks, input int odd_ticks);
        logic [9:0] bits;
        bits = {stop_bit, data_byte, 1'b0};
        for (int j = 0; j < 10; j++) begin
            serial_in = bits[j];
            repeat ((j % 2 == 0) ? even_ticks : odd_ticks) wait_tick();
        end
        serial_in = 1'b1;
    endtask

    // 8N1 rules: a low stop bit is flagged, a frame for a full FIFO is lost.
    function automatic void model_push(input rx_byte_t data_byte, input logic stop_bit);
        rx_frame_t f;
        f.data          = data_byte;
        f.framing_error = ~stop_bit;
        if (expected_q.size() >= FIFO_DEPTH) begin
            expected_overrun = 1'b1;
        end else begin
            expected_q.push_back(f);
        end
    endfunction

    task automatic read_and_check(input string what);
        rx_frame_t expected;
        int        waited;
        waited = 0;
        while (empty && waited < READ_WAIT_TICKS) begin
            wait_tick();
            waited++;
        end
        if (empty) begin
            checks_failed++;
            $display("no frame arrived within %0d ticks during %s, at %0t",
                     READ_WAIT_TICKS, what, $time);
            if (expected_q.size() > 0) begin
                void'(expected_q.pop_front());
            end
        end else begin
            if (expected_q.size() == 0) begin
                checks_failed++;
                $display("a frame arrived that was never sent during %s, at %0t",
                         what, $time);
            end else begin
                expected = expected_q.pop_front();
                check_value({what, " data"}, 32'(rd_frame.data), 32'(expected.data));
                check_value({what, " framing_error"}, 32'(rd_frame.framing_error),
                            32'(expected.framing_error));
            end
            rd_en = 1'b1;
            wait_tick();
            rd_en = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int failed_before);
        $display("test %s finished with %0d errors", name, checks_failed - failed_before);
    endtask

    task automatic test_reset_state();
        int failed_before;
        failed_before = checks_failed;
        check_value("empty after reset", 32'(empty), 32'd1);
        check_value("overrun after reset", 32'(overrun), 32'd0);
        check_value("rd_frame unknown after reset", 32'($isunknown(rd_frame)), 32'd0);
        finish_test("reset state", failed_before);
    endtask

    task automatic test_random_bytes();
        int       failed_before;
        rx_byte_t data_byte;
        failed_before = checks_failed;
        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            data_byte = 8'($urandom);
            idle_line($urandom_range(0, 40));
            model_push(data_byte, 1'b1);
            send_frame(data_byte, 1'b1, 16, 16);
            read_and_check("random byte");
        end
        check_value("overrun after random bytes", 32'(overrun), 32'(expected_overrun));
        finish_test("random bytes", failed_before);
    endtask

    task automatic test_framing_error();
        int       failed_before;
        rx_byte_t data_byte;
        logic     bad_stop;
        failed_before = checks_failed;
        for (int i = 0; i < FRAMING_FRAMES; i++) begin
            data_byte = 8'($urandom);
            bad_stop  = (i % 3 == 1) || ($urandom_range(0, 4) == 0);
            model_push(data_byte, ~bad_stop);
            send_frame(data_byte, ~bad_stop, 16, 16);
            // the line has to sit high before the next start edge counts.
            idle_line(16 + $urandom_range(0, 16));
            read_and_check("framing error");
        end
        finish_test("framing error", failed_before);
    endtask

    task automatic test_noise();
        int       failed_before;
        rx_byte_t data_byte;
        failed_before = checks_failed;
        for (int i = 0; i < 6; i++) begin
            serial_in = 1'b0;
            wait_tick();
            idle_line(20 + $urandom_range(0, 10));
        end
        // long enough to pass the filter, too short for a start bit.
        for (int i = 0; i < 4; i++) begin
            serial_in = 1'b0;
            repeat (4) wait_tick();
            idle_line(30);
        end
        // a start taken from the last pulse would have finished its frame by now.
        idle_line(10 * BIT_TICKS);
        check_value("empty after glitches", 32'(empty), 32'd1);
        data_byte = 8'($urandom);
        model_push(data_byte, 1'b1);
        send_frame(data_byte, 1'b1, 16, 16);
        read_and_check("frame after noise");
        finish_test("noise and false start", failed_before);
    endtask

    task automatic test_overrun();
        int       failed_before;
        rx_byte_t data_byte;
        failed_before = checks_failed;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            data_byte = 8'($urandom);
            model_push(data_byte, 1'b1);
            send_frame(data_byte, 1'b1, 16, 16);
            idle_line($urandom_range(1, 8));
        end
        check_value("overrun with full FIFO", 32'(overrun), 32'(expected_overrun));
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_and_check("overrun");
        end
        check_value("empty after draining", 32'(empty), 32'd1);
        finish_test("overrun", failed_before);
    endtask

    task automatic test_rate_tolerance();
        int       failed_before;
        rx_byte_t data_byte;
        failed_before = checks_failed;
        for (int i = 0; i < RATE_FRAMES; i++) begin
            data_byte = 8'($urandom);
            model_push(data_byte, 1'b1);
            if (i % 2 == 0) begin
                send_frame(data_byte, 1'b1, 15, 17);
            end else begin
                send_frame(data_byte, 1'b1, 17, 15);
            end
            idle_line($urandom_range(1, 8));
            read_and_check("rate tolerance");
        end
        finish_test("rate tolerance", failed_before);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'hb85004cb));
        serial_in        = 1'b1;
        rd_en            = 1'b0;
        expected_overrun = 1'b0;
        checks_passed    = 0;
        checks_failed    = 0;

        wait (reset === 1'b0);
        wait_tick();

        test_reset_state();
        test_random_bytes();
        test_framing_error();
        test_noise();
        test_overrun();
        test_rate_tolerance();

        $display("checks: %0d passed, %0d failed", checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out at %0t before all tests finished", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* verification/uart_receiver_assert.sv */
`timescale 1ns/10ps

module uart_receiver_assert (
    input logic                   baud16,
    input logic                   reset,
    input uart_rx_pkg::rx_frame_t rd_frame,
    input logic                   empty,
    input logic                   overrun
);

    // overrun is sticky until the next reset.
    overrun_sticky: assert property (
        @(posedge baud16) disable iff (reset) !$fell(overrun)
    ) else $error("overrun cleared without a reset");

    // the fall-through head must hold real data.
    head_known: assert property (
        @(posedge baud16) disable iff (reset) !empty |-> !$isunknown(rd_frame)
    ) else $error("rd_frame unknown while the FIFO holds data");

    empty_after_reset: assert property (
        @(posedge baud16) $fell(reset) |-> empty
    ) else $error("FIFO not empty in the first cycle after reset");

endmodule

bind uart_receiver uart_receiver_assert u_assert (
    .baud16   (baud16),
    .reset    (reset),
    .rd_frame (rd_frame),
    .empty    (empty),
    .overrun  (overrun)
);
